// File: bpuPkg.sv
`default_nettype none

`include "bpu_defs.svh"

package bpuPkg;

    typedef logic [`VADDR_MSB:0] Vaddr;

    // slot index with a wrap flag on top
    typedef logic [`RAS_CKPT_WIDTH:0] CkptTag;

    // bit 1 pushes, bit 0 pops
    typedef enum logic [1:0] {
        NONE     = 2'b00,
        POP      = 2'b01,
        PUSH     = 2'b10,
        POP_PUSH = 2'b11
    } RasKind;

endpackage

`default_nettype wire

// File: bpu_defs.svh
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// committed return stack
`define RAS_DEPTH 16
`define RAS_WIDTH $clog2(`RAS_DEPTH)

// speculative push list
`define RAS_INFLIGHT_DEPTH 8
`define RAS_INFLIGHT_WIDTH $clog2(`RAS_INFLIGHT_DEPTH)

// one slot per outstanding lookup
`define RAS_CKPT_DEPTH 8
`define RAS_CKPT_WIDTH $clog2(`RAS_CKPT_DEPTH)

`define VADDR_WIDTH 32
`define VADDR_MSB (`VADDR_WIDTH - 1)

`endif

// File: project.f
+incdir+.
bpuPkg.sv
rasPkg.sv
rasIo.sv
rasRam.sv
returnStack.sv
rasCheckpointQueue.sv
rasTop.sv
rasTb.sv

// File: rasCheckpointQueue.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module rasCheckpointQueue (
    input logic clk,
    input logic rst,
    input logic lookupValid,
    output logic lookupReady,
    input bpuPkg::RasKind lookupKind,
    input bpuPkg::Vaddr lookupTarget,
    output bpuPkg::CkptTag lookupTag,
    input logic squashValid,
    input bpuPkg::CkptTag squashTag,
    input bpuPkg::RasKind squashKind,
    input bpuPkg::Vaddr squashTarget,
    input logic commitValid,
    input bpuPkg::RasKind commitKind,
    input bpuPkg::Vaddr commitTarget,
    output logic predValid,
    rasIo.queue io
);

    bpuPkg::CkptTag head, tail;
    rasPkg::RasSnapshot snaps [`RAS_CKPT_DEPTH];
    logic full, empty, accept;

    assign empty = head == tail;
    assign full = (head[`RAS_CKPT_WIDTH-1:0] == tail[`RAS_CKPT_WIDTH-1:0]) &&
                  (head[`RAS_CKPT_WIDTH] != tail[`RAS_CKPT_WIDTH]);

    assign lookupReady = ~full & ~squashValid;      // squash wins the cycle
    assign accept = lookupValid & lookupReady;
    assign lookupTag = tail;

    assign io.request = accept;
    assign io.kind = lookupKind;
    assign io.target = lookupTarget;

    assign io.squash = squashValid;
    assign io.squashKind = squashKind;
    assign io.squashTarget = squashTarget;
    assign io.squashSnap = snaps[squashTag[`RAS_CKPT_WIDTH-1:0]];

    assign io.commit = commitValid;
    assign io.commitKind = commitKind;
    assign io.commitTarget = commitTarget;

    always_ff @(posedge clk) begin
        if (accept) begin
            snaps[tail[`RAS_CKPT_WIDTH-1:0]] <= io.snap;
        end
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            head <= '0;
            tail <= '0;
            predValid <= 1'b0;
        end else begin
            predValid <= accept & lookupKind[0];
            if (squashValid) begin
                tail <= squashTag + 1'b1;           // drop younger lookups
            end else if (accept) begin
                tail <= tail + 1'b1;
            end
            if (commitValid) begin
                head <= head + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst) commitValid |-> !empty)
        else $error("commit with no outstanding lookup");

endmodule

`default_nettype wire

// File: rasIo.sv
`timescale 1ns/10ps
`default_nettype none

interface rasIo;

    logic request;
    bpuPkg::RasKind kind;
    bpuPkg::Vaddr target;

    logic squash;
    bpuPkg::RasKind squashKind;
    bpuPkg::Vaddr squashTarget;
    rasPkg::RasSnapshot squashSnap;         // state before the squashed lookup

    logic commit;
    bpuPkg::RasKind commitKind;
    bpuPkg::Vaddr commitTarget;

    rasPkg::RasSnapshot snap;
    bpuPkg::Vaddr predAddr;

    modport queue (
        output request, kind, target,
        output squash, squashKind, squashTarget, squashSnap,
        output commit, commitKind, commitTarget,
        input snap, predAddr
    );

    modport stack (
        input request, kind, target,
        input squash, squashKind, squashTarget, squashSnap,
        input commit, commitKind, commitTarget,
        output snap, predAddr
    );

endinterface

`default_nettype wire

// File: rasPkg.sv
`default_nettype none

`include "bpu_defs.svh"

package rasPkg;

    typedef struct packed {
        logic dir;                              // flips on each wrap
        logic [`RAS_INFLIGHT_WIDTH-1:0] idx;
    } RasInflightIdx;

    typedef logic [`RAS_WIDTH-1:0] RasCommitIdx;

    typedef bpuPkg::Vaddr RasEntry;

    // pointer state taken at each lookup
    typedef struct packed {
        RasInflightIdx rasTop;                  // one past the top entry
        RasInflightIdx listTop;                 // next free list slot
        RasCommitIdx inflightTop;               // speculative stack depth
        logic topInvalid;                       // top lives in committed stack
    } RasSnapshot;

endpackage

`default_nettype wire

// File: rasRam.sv
`timescale 1ns/10ps
`default_nettype none

module rasRam #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input logic clk,
    input logic we,
    input logic [$clog2(DEPTH)-1:0] waddr,
    input logic [WIDTH-1:0] wdata,
    input logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0] rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];                // old data on same-address write
    end

    assert property (@(posedge clk) we |-> !$isunknown(waddr))
        else $error("rasRam write to an unknown address");

endmodule

`default_nettype wire

// File: rasTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module rasTb;

    localparam int WAIT_LIMIT = 20;
    localparam int MODEL_SIZE = 64;

    logic clk;
    logic rst;
    logic lookupValid;
    logic lookupReady;
    bpuPkg::RasKind lookupKind;
    bpuPkg::Vaddr lookupTarget;
    bpuPkg::CkptTag lookupTag;
    logic squashValid;
    bpuPkg::CkptTag squashTag;
    bpuPkg::RasKind squashKind;
    bpuPkg::Vaddr squashTarget;
    logic commitValid;
    bpuPkg::RasKind commitKind;
    bpuPkg::Vaddr commitTarget;
    logic predValid;
    bpuPkg::Vaddr predAddr;

    logic [15:0] lfsr;
    bpuPkg::Vaddr model [MODEL_SIZE];           // software stack with index 0 at the bottom
    int depth;
    bpuPkg::Vaddr savedStack [`RAS_CKPT_DEPTH][MODEL_SIZE];
    int savedDepth [`RAS_CKPT_DEPTH];
    bpuPkg::RasKind pendKind [`RAS_CKPT_DEPTH];
    bpuPkg::Vaddr pendTarget [`RAS_CKPT_DEPTH];
    bpuPkg::CkptTag tbHead, tbTail;             // oldest and next tag
    bpuPkg::Vaddr expQ [$];
    bpuPkg::Vaddr checkExp;

    string curTest;
    int testErrors, testChecks, errorCount, checkCount, testCount, failedTests;
    int round, i, n, waited;
    bpuPkg::CkptTag wrongTag;
    bpuPkg::RasKind kindSel;

    rasTop UUT (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupReady(lookupReady),
        .lookupKind(lookupKind),
        .lookupTarget(lookupTarget),
        .lookupTag(lookupTag),
        .squashValid(squashValid),
        .squashTag(squashTag),
        .squashKind(squashKind),
        .squashTarget(squashTarget),
        .commitValid(commitValid),
        .commitKind(commitKind),
        .commitTarget(commitTarget),
        .predValid(predValid),
        .predAddr(predAddr)
    );

    always #50 clk = ~clk;

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] v;
        int k;
        v = '0;
        for (k = 0; k < count; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic bpuPkg::Vaddr randTarget();
        return randBits(30) << 2;               // word aligned
    endfunction

    function automatic int outstanding();
        bpuPkg::CkptTag diff;
        diff = tbTail - tbHead;
        return int'(diff);
    endfunction

    // expected top before the branch, then the branch's effect on the model
    function automatic bpuPkg::Vaddr modelStep(input bpuPkg::RasKind k, input bpuPkg::Vaddr t);
        bpuPkg::Vaddr topVal;
        topVal = (depth > 0) ? model[depth-1] : '0;
        if (k[0] && depth > 0) begin
            depth = depth - 1;
        end
        if (k[1]) begin
            model[depth] = t;
            depth = depth + 1;
        end
        return topVal;
    endfunction

    function automatic void saveModel(input int slot);
        int j;
        savedDepth[slot] = depth;
        for (j = 0; j < depth; j++) begin
            savedStack[slot][j] = model[j];
        end
    endfunction

    function automatic void restoreModel(input int slot);
        int j;
        depth = savedDepth[slot];
        for (j = 0; j < depth; j++) begin
            model[j] = savedStack[slot][j];
        end
    endfunction

    task automatic flagMismatch(input string what, input logic [31:0] expv,
                                input logic [31:0] actv);
        $display("** Error %s: %s expected %h, actual %h", curTest, what, expv, actv);
        testErrors++;
        errorCount++;
    endtask

    task automatic flagProblem(input string msg);
        $display("%s: %s", curTest, msg);
        testErrors++;
        errorCount++;
    endtask

    task automatic checkValue(input string what, input logic [31:0] expv,
                              input logic [31:0] actv);
        testChecks++;
        checkCount++;
        if (expv !== actv) begin
            flagMismatch(what, expv, actv);
        end
    endtask

    // prediction for each accepted popping lookup
    always @(negedge clk) begin
        if (rst && predValid) begin
            if (expQ.size() == 0) begin
                flagProblem("predValid high with no prediction pending");
            end else begin
                checkExp = expQ.pop_front();
                checkValue("predAddr", checkExp, predAddr);
            end
        end
    end

    task automatic idleCycle();
        @(negedge clk);
        lookupValid = 1'b0;
        squashValid = 1'b0;
        commitValid = 1'b0;
    endtask

    // called at a falling edge and holds the lookup until it is accepted
    task automatic presentLookup(input bpuPkg::RasKind k, input bpuPkg::Vaddr t,
                                 output int cycles);
        int slot;
        bpuPkg::Vaddr expTop;
        squashValid = 1'b0;
        commitValid = 1'b0;
        lookupValid = 1'b1;
        lookupKind = k;
        lookupTarget = t;
        cycles = 0;
        #1;
        while (!lookupReady && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (!lookupReady) begin
            flagProblem("lookupReady stayed low, lookup never accepted");
            lookupValid = 1'b0;
        end else begin
            checkValue("lookupTag", tbTail, lookupTag);
            slot = int'(tbTail[`RAS_CKPT_WIDTH-1:0]);
            saveModel(slot);
            pendKind[slot] = k;
            pendTarget[slot] = t;
            expTop = modelStep(k, t);
            if (k[0]) begin
                expQ.push_back(expTop);
            end
            tbTail = tbTail + 1'b1;
        end
    endtask

    task automatic lookup(input bpuPkg::RasKind k, input bpuPkg::Vaddr t);
        int cycles;
        @(negedge clk);
        presentLookup(k, t, cycles);
    endtask

    task automatic loadCommit();
        int slot;
        slot = int'(tbHead[`RAS_CKPT_WIDTH-1:0]);
        commitValid = 1'b1;
        commitKind = pendKind[slot];
        commitTarget = pendTarget[slot];
        tbHead = tbHead + 1'b1;
    endtask

    task automatic commitOldest();
        @(negedge clk);
        lookupValid = 1'b0;
        squashValid = 1'b0;
        loadCommit();
    endtask

    task automatic commitSome();
        if (outstanding() == `RAS_CKPT_DEPTH || (outstanding() > 0 && randBits(1))) begin
            commitOldest();
        end
    endtask

    task automatic commitAll();
        while (outstanding() > 0) begin
            commitOldest();
        end
        idleCycle();
    endtask

    // redirect to a tag and replay that branch with its real kind
    task automatic squashTo(input bpuPkg::CkptTag tag, input bpuPkg::RasKind k,
                            input bpuPkg::Vaddr t);
        int slot;
        @(negedge clk);
        lookupValid = 1'b0;
        commitValid = 1'b0;
        squashValid = 1'b1;
        squashTag = tag;
        squashKind = k;
        squashTarget = t;
        slot = int'(tag[`RAS_CKPT_WIDTH-1:0]);
        restoreModel(slot);
        void'(modelStep(k, t));
        pendKind[slot] = k;
        pendTarget[slot] = t;
        tbTail = tag + 1'b1;
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        testErrors = 0;
        testChecks = 0;
    endtask

    task automatic endTest();
        int cycles;
        idleCycle();
        cycles = 0;
        #1;
        while (expQ.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #1;
            cycles++;
        end
        if (expQ.size() != 0) begin
            flagProblem("predValid never came for a popping lookup");
            expQ.delete();
        end
        testCount++;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test %-16s %s, %0d checks, %0d errors", curTest,
                 (testErrors == 0) ? "passed" : "failed", testChecks, testErrors);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        lookupValid = 1'b0;
        lookupKind = bpuPkg::NONE;
        lookupTarget = '0;
        squashValid = 1'b0;
        squashTag = '0;
        squashKind = bpuPkg::NONE;
        squashTarget = '0;
        commitValid = 1'b0;
        commitKind = bpuPkg::NONE;
        commitTarget = '0;
        lfsr = 16'd22;
        depth = 0;
        tbHead = '0;
        tbTail = '0;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        failedTests = 0;
        beginTest("reset");

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        repeat (3) begin
            @(negedge clk);
            #1;
            checkValue("predValid", 0, predValid);
            checkValue("lookupReady", 1, lookupReady);
        end
        endTest();

        beginTest("nested calls");
        for (round = 0; round < 4; round++) begin
            n = 1 + randBits(3);
            for (i = 0; i < n; i++) begin
                commitSome();
                lookup(bpuPkg::PUSH, randTarget());
            end
            for (i = 0; i < n; i++) begin
                commitSome();
                lookup(bpuPkg::POP, '0);
            end
            commitAll();
        end
        endTest();

        beginTest("push-pop bypass");
        lookup(bpuPkg::PUSH, randTarget());
        lookup(bpuPkg::PUSH, randTarget());
        lookup(bpuPkg::POP, '0);                // back to back with the push
        lookup(bpuPkg::PUSH, randTarget());
        lookup(bpuPkg::POP, '0);
        lookup(bpuPkg::POP, '0);
        commitAll();
        lookup(bpuPkg::PUSH, randTarget());
        lookup(bpuPkg::POP_PUSH, randTarget()); // replaces the entry pushed just before
        lookup(bpuPkg::POP, '0);
        commitAll();
        endTest();

        beginTest("squash recovery");
        lookup(bpuPkg::PUSH, randTarget());
        lookup(bpuPkg::PUSH, randTarget());
        wrongTag = tbTail;
        lookup(bpuPkg::POP, '0);                // wrong path from here
        lookup(bpuPkg::PUSH, randTarget());     // lands where the popped entry was
        squashTo(wrongTag, bpuPkg::NONE, '0);
        lookup(bpuPkg::POP, '0);
        lookup(bpuPkg::POP, '0);
        commitAll();
        lookup(bpuPkg::PUSH, randTarget());
        wrongTag = tbTail;
        lookup(bpuPkg::POP, '0);
        squashTo(wrongTag, bpuPkg::PUSH, randTarget());
        lookup(bpuPkg::POP, '0);
        lookup(bpuPkg::POP, '0);
        commitAll();
        endTest();

        beginTest("deep recursion");
        n = `RAS_INFLIGHT_DEPTH + 1 + randBits(2);
        for (i = 0; i < n; i++) begin
            if (outstanding() >= 4) begin
                commitOldest();
            end
            lookup(bpuPkg::PUSH, randTarget());
        end
        commitAll();
        for (i = 0; i < n; i++) begin
            if (outstanding() >= 4) begin
                commitOldest();
            end
            lookup(bpuPkg::POP, '0);
        end
        commitAll();
        endTest();

        beginTest("back-pressure");
        for (i = 0; i < `RAS_CKPT_DEPTH; i++) begin
            if (i < 4) begin
                kindSel = bpuPkg::PUSH;
            end else begin
                kindSel = bpuPkg::NONE;
            end
            lookup(kindSel, randTarget());
        end
        @(negedge clk);
        lookupValid = 1'b1;                     // held while the queue is full
        lookupKind = bpuPkg::POP;
        lookupTarget = '0;
        #1;
        checkValue("lookupReady with all slots used", 0, lookupReady);
        @(negedge clk);
        loadCommit();
        #1;
        checkValue("lookupReady in the commit cycle", 0, lookupReady);
        @(negedge clk);
        presentLookup(bpuPkg::POP, '0, waited);
        checkValue("extra cycles held after the commit", 0, waited);
        commitAll();
        endTest();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rasTop.sv
`timescale 1ns/10ps
`default_nettype none

module rasTop (
    input logic clk,
    input logic rst,
    input logic lookupValid,
    output logic lookupReady,
    input bpuPkg::RasKind lookupKind,
    input bpuPkg::Vaddr lookupTarget,
    output bpuPkg::CkptTag lookupTag,
    input logic squashValid,
    input bpuPkg::CkptTag squashTag,
    input bpuPkg::RasKind squashKind,
    input bpuPkg::Vaddr squashTarget,
    input logic commitValid,
    input bpuPkg::RasKind commitKind,
    input bpuPkg::Vaddr commitTarget,
    output logic predValid,
    output bpuPkg::Vaddr predAddr
);

    rasIo io ();

    rasCheckpointQueue ckptQueue (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupReady(lookupReady),
        .lookupKind(lookupKind),
        .lookupTarget(lookupTarget),
        .lookupTag(lookupTag),
        .squashValid(squashValid),
        .squashTag(squashTag),
        .squashKind(squashKind),
        .squashTarget(squashTarget),
        .commitValid(commitValid),
        .commitKind(commitKind),
        .commitTarget(commitTarget),
        .predValid(predValid),
        .io(io.queue)
    );

    returnStack stack (
        .clk(clk),
        .rst(rst),
        .io(io.stack)
    );

    assign predAddr = io.predAddr;

endmodule

`default_nettype wire

// File: returnStack.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpu_defs.svh"

module returnStack (
    input logic clk,
    input logic rst,
    rasIo.stack io
);

    rasPkg::RasInflightIdx top, listTop, listBottom;
    rasPkg::RasInflightIdx topP1, listTopN1, listBottomN1;
    rasPkg::RasInflightIdx rTopP1, rListTopN1;
    rasPkg::RasInflightIdx link, rLink;
    rasPkg::RasInflightIdx [`RAS_INFLIGHT_DEPTH-1:0] topList;   // previous top per slot
    logic [`RAS_INFLIGHT_DEPTH-1:0] topInvalid;
    logic preTopInvalid;
    rasPkg::RasSnapshot r;

    rasPkg::RasCommitIdx commitTop, inflightTop;
    rasPkg::RasCommitIdx commitRaddr, commitWaddr;
    logic commitWe;

    logic we;
    logic [`RAS_INFLIGHT_WIDTH-1:0] waddr;
    rasPkg::RasEntry updateEntry, listEntry, commitEntry, bypassEntry;

    logic popReq;
    logic lastPush;                         // list written in the previous cycle
    logic selCommit, selBypass;
    logic [`RAS_INFLIGHT_WIDTH:0] listFill;

    function automatic logic inRange(rasPkg::RasInflightIdx a);
        logic belowBottom;
        logic belowTop;
        belowBottom = (listBottom.dir ^ a.dir) ^ (a.idx < listBottom.idx);
        belowTop = (listTop.dir ^ a.dir) ^ (a.idx < listTop.idx);
        return ~belowBottom & belowTop;
    endfunction

    function automatic rasPkg::RasCommitIdx stepPtr(rasPkg::RasCommitIdx p,
                                                    bpuPkg::RasKind k);
        case (k)
            bpuPkg::PUSH: return p + 1'b1;
            bpuPkg::POP: return p - 1'b1;
            default: return p;              // pop-push keeps depth
        endcase
    endfunction

    assign r = io.squashSnap;
    assign topP1 = top - 1'b1;
    assign listTopN1 = listTop + 1'b1;
    assign listBottomN1 = listBottom + 1'b1;
    assign rTopP1 = r.rasTop - 1'b1;
    assign rListTopN1 = r.listTop + 1'b1;
    assign link = topList[topP1.idx];
    assign rLink = topList[rTopP1.idx];

    assign popReq = ~io.squash & io.request & io.kind[0];
    assign we = io.squash ? io.squashKind[1] : io.request & io.kind[1];
    assign waddr = io.squash ? r.listTop.idx : listTop.idx;
    assign updateEntry = io.squash ? io.squashTarget : io.target;

    assign commitRaddr = inflightTop - 1'b1;
    assign commitWaddr = (io.commitKind == bpuPkg::POP_PUSH) ? commitTop - 1'b1 : commitTop;
    assign commitWe = io.commit & io.commitKind[1];

    assign io.snap.rasTop = top;
    assign io.snap.listTop = listTop;
    assign io.snap.inflightTop = inflightTop;
    assign io.snap.topInvalid = preTopInvalid;

    assign io.predAddr = selBypass ? bypassEntry :
                         selCommit ? commitEntry : listEntry;

    rasRam #(
        .DEPTH(`RAS_INFLIGHT_DEPTH),
        .WIDTH($bits(rasPkg::RasEntry))
    ) inflightRam (
        .clk(clk),
        .we(we),
        .waddr(waddr),
        .wdata(updateEntry),
        .raddr(topP1.idx),
        .rdata(listEntry)
    );

    rasRam #(
        .DEPTH(`RAS_DEPTH),
        .WIDTH($bits(rasPkg::RasEntry))
    ) commitRam (
        .clk(clk),
        .we(commitWe),
        .waddr(commitWaddr),
        .wdata(io.commitTarget),
        .raddr(commitRaddr),
        .rdata(commitEntry)
    );

    always_ff @(posedge clk) begin
        if (we) begin
            bypassEntry <= updateEntry;
        end
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            lastPush <= 1'b0;
            selBypass <= 1'b0;
            selCommit <= 1'b0;
        end else begin
            lastPush <= we;
            if (popReq) begin
                selBypass <= lastPush & ~io.kind[1];    // pop-push overwrites the bypass
                selCommit <= ~inRange(topP1) | preTopInvalid;
            end
        end
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            top <= '0;
            listTop <= '0;
            listBottom <= '0;
            topList <= '0;
            topInvalid <= '0;
            preTopInvalid <= 1'b0;
            inflightTop <= '0;
            commitTop <= '0;
        end else begin
            if (io.squash) begin
                if (io.squashKind[1]) begin
                    topList[r.listTop.idx] <= io.squashKind[0] ? rLink : r.rasTop;
                    topInvalid[r.listTop.idx] <= r.topInvalid;
                    preTopInvalid <= 1'b0;
                    listTop <= rListTopN1;
                    top <= rListTopN1;
                end else if (io.squashKind[0]) begin
                    listTop <= r.listTop;
                    if (inRange(rLink) & ~topInvalid[rTopP1.idx] & ~r.topInvalid) begin
                        top <= rLink;
                        preTopInvalid <= 1'b0;
                    end else begin
                        top <= r.rasTop;
                        preTopInvalid <= 1'b1;      // fall back to committed copy
                    end
                end else begin
                    listTop <= r.listTop;
                    top <= r.rasTop;
                    preTopInvalid <= r.topInvalid;
                end
                inflightTop <= stepPtr(r.inflightTop, io.squashKind);
            end else if (io.request) begin
                if (io.kind[1]) begin
                    topList[listTop.idx] <= io.kind[0] ? link : top;
                    topInvalid[listTop.idx] <= preTopInvalid;
                    preTopInvalid <= 1'b0;
                    listTop <= listTopN1;
                    top <= listTopN1;
                end else if (io.kind[0]) begin
                    if (inRange(link) & ~topInvalid[topP1.idx] & ~preTopInvalid) begin
                        top <= link;
                    end else begin
                        preTopInvalid <= 1'b1;
                    end
                end
                inflightTop <= stepPtr(inflightTop, io.kind);
            end

            if (io.commit) begin
                commitTop <= stepPtr(commitTop, io.commitKind);
                if (io.commitKind[1]) begin
                    listBottom <= listBottomN1;     // oldest list slot retired
                end
            end
        end
    end

    assign listFill = listTop - listBottom;

    assert property (@(posedge clk) disable iff (!rst) !(io.squash && io.request))
        else $error("squash and lookup in the same cycle");

    assert property (@(posedge clk) disable iff (!rst) listFill <= `RAS_INFLIGHT_DEPTH)
        else $error("in-flight list bottom passed its top");

endmodule

`default_nettype wire
